// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_exec_cluster
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none
// ==================================================
// Random-stimulus testbench for the execution cluster.
// A scoreboard keyed by ROB index checks every CDB beat.
// ==================================================

module tb_exec_cluster
	import ooo_pkg::*;
;

	localparam int PRF_SIZE    = 64;
	localparam int ROB_SIZE    = 32;
	localparam int TAG_W       = $clog2(PRF_SIZE);
	localparam int ROB_W       = $clog2(ROB_SIZE) + 1;
	localparam int ROB_SPAN    = 1 << ROB_W;
	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 500;
	localparam int NUM_RANDOM  = 200;

	logic              clock;
	logic              arst_n;
	logic              issue_valid;
	op_e               issue_op;
	logic [DATA_W-1:0] issue_a;
	logic [DATA_W-1:0] issue_b;
	logic [TAG_W-1:0]  issue_tag;
	logic [ROB_W-1:0]  issue_rob;
	logic              issue_stall;
	logic              issue_illegal;
	logic              cdb_valid;
	logic [TAG_W-1:0]  cdb_tag;
	logic [DATA_W-1:0] cdb_out;
	logic [ROB_W-1:0]  cdb_rob_idx;

	// Scoreboard, keyed by ROB index.
	logic [DATA_W-1:0] exp_val [int];
	logic [TAG_W-1:0]  exp_tag [int];
	int                acc_edge [int];
	int                lat [int];
	int                bcyc [int];
	bit                illegal_rob [int];

	// Run state and counters.
	int    cyc;
	int    rob_ctr;
	int    beats;
	int    accepted;
	int    checks;
	int    errors;
	int    tests;
	int    failed_tests;
	int    test_err_start;
	int    mon_rob;
	bit    timed_out;
	bit    saw_stall;
	string cur_test;

	exec_cluster_top #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_dut (
		.clock(clock), .arst_n(arst_n),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b),
		.issue_tag(issue_tag), .issue_rob(issue_rob),
		.issue_stall(issue_stall), .issue_illegal(issue_illegal),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
		.cdb_out(cdb_out), .cdb_rob_idx(cdb_rob_idx)
	);

	// 4 ns clock.
	always #2 clock = ~clock;

	// Edge counter, read only on falling edges.
	always @(posedge clock)
	begin
		cyc <= cyc + 1;
	end

	// ==================================================
	// Reference model and checks
	// ==================================================

	// Expected result straight from the opcode definitions.
	function automatic logic [DATA_W-1:0] model_result(input int code,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		case (code)
			0:       return a + b;
			1:       return a - b;
			2:       return a & b;
			3:       return a | b;
			4:       return a ^ b;
			5:       return a * b;
			default: return '0;
		endcase
	endfunction

	task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	// CDB is driven from unit registers only, so mid-cycle is a stable sample point.
	always @(negedge clock)
	begin
		if (arst_n && cdb_valid)
		begin
			beats++;
			mon_rob = int'(cdb_rob_idx);
			if (exp_val.exists(mon_rob))
			begin
				compare("cdb_out", exp_val[mon_rob], cdb_out);
				compare("cdb_tag", 64'(exp_tag[mon_rob]), 64'(cdb_tag));
				lat[mon_rob]  = cyc - acc_edge[mon_rob] + 1;
				bcyc[mon_rob] = cyc;
				exp_val.delete(mon_rob);
				exp_tag.delete(mon_rob);
			end
			else if (illegal_rob.exists(mon_rob))
			begin
				errors++;
				$display("%s: CDB beat for rob %0d, which carried an illegal opcode",
					cur_test, mon_rob);
			end
			else
			begin
				errors++;
				$display("%s: CDB beat for rob %0d with no outstanding operation",
					cur_test, mon_rob);
			end
		end
	end

	// ==================================================
	// Stimulus tasks
	// ==================================================

	// Present one operation and hold it until it is taken.
	task automatic send(input int code, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, output int rob);
		int               waited;
		logic [TAG_W-1:0] tag;
		rob = rob_ctr;
		if (timed_out)
			return;
		tag = TAG_W'($urandom);
		@(negedge clock);
		issue_valid = 1'b1;
		issue_op    = op_e'(code[2:0]);
		issue_a     = a;
		issue_b     = b;
		issue_tag   = tag;
		issue_rob   = ROB_W'(rob_ctr);
		// Stall settles from the inputs and from unit state before the next edge.
		#1;
		waited = 0;
		while (issue_stall && waited < STALL_LIMIT)
		begin
			saw_stall = 1'b1;
			@(negedge clock);
			#1;
			waited++;
		end
		if (issue_stall)
		begin
			timed_out = 1'b1;
			errors++;
			$display("%s: issue stalled for %0d cycles without progress", cur_test, waited);
		end
		else if (code > 5)
		begin
			compare("issue_illegal", 64'd1, 64'(issue_illegal));
			illegal_rob[rob] = 1'b1;
		end
		else
		begin
			compare("issue_illegal", 64'd0, 64'(issue_illegal));
			exp_val[rob]  = model_result(code, a, b);
			exp_tag[rob]  = tag;
			acc_edge[rob] = cyc + 1;
			accepted++;
		end
		// Unique counter, the top bit acts as wrap bit.
		rob_ctr = (rob_ctr + 1) % ROB_SPAN;
	endtask

	task automatic idle();
		@(negedge clock);
		issue_valid = 1'b0;
	endtask

	// Wait until every accepted operation has shown up on the CDB.
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_val.num() > 0 && waited < DRAIN_LIMIT && !timed_out)
		begin
			@(negedge clock);
			waited++;
		end
		if (exp_val.num() > 0 && !timed_out)
		begin
			timed_out = 1'b1;
			errors++;
			$display("%s: %0d results never reached the CDB", cur_test, exp_val.num());
		end
	endtask

	task automatic begin_test(input string name);
		cur_test       = name;
		test_err_start = errors;
		tests++;
	endtask

	task automatic end_test();
		int n;
		n = errors - test_err_start;
		if (n != 0)
			failed_tests++;
		$display("test %-10s : %0d errors", cur_test, n);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial
	begin : main
		int r0;
		int r1;
		int code;
		int beats0;
		int acc0;
		clock = 1'b0;
		arst_n = 1'b0;
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_a = '0;
		issue_b = '0;
		issue_tag = '0;
		issue_rob = '0;
		void'($urandom(32'hce8c));
		repeat (10) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;

		// Idle bus straight out of reset.
		begin_test("reset");
		@(negedge clock);
		compare("cdb_valid", 64'd0, 64'(cdb_valid));
		compare("issue_stall", 64'd0, 64'(issue_stall));
		compare("cdb_out", 64'd0, cdb_out);
		compare("cdb_tag", 64'd0, 64'(cdb_tag));
		compare("cdb_rob_idx", 64'd0, 64'(cdb_rob_idx));
		end_test();

		// Back-to-back legal operations of every kind.
		begin_test("random");
		beats0 = beats;
		acc0 = accepted;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			code = int'($urandom % 6);
			send(code, {$urandom, $urandom}, {$urandom, $urandom}, r0);
		end
		idle();
		drain();
		repeat (8) @(negedge clock);
		compare("beat count", 64'(accepted - acc0), 64'(beats - beats0));
		end_test();

		// Single operations on an idle cluster.
		begin_test("latency");
		send(0, {$urandom, $urandom}, {$urandom, $urandom}, r0);
		idle();
		drain();
		send(5, {$urandom, $urandom}, {$urandom, $urandom}, r1);
		idle();
		drain();
		if (!timed_out)
		begin
			compare("add latency", 64'd1, 64'(lat[r0]));
			compare("mul latency", 64'd3, 64'(lat[r1]));
		end
		end_test();

		// Multiply at t and add at t+2 collide on the bus.
		begin_test("priority");
		send(5, {$urandom, $urandom}, {$urandom, $urandom}, r0);
		idle();
		send(1, {$urandom, $urandom}, {$urandom, $urandom}, r1);
		idle();
		drain();
		if (!timed_out)
		begin
			compare("mul latency", 64'd3, 64'(lat[r0]));
			compare("add after mul", 64'd1, 64'(bcyc[r1] - bcyc[r0]));
		end
		end_test();

		// A stream of multiplies holds the bus so both adders fill up.
		begin_test("stall");
		saw_stall = 1'b0;
		for (int i = 0; i < 8; i++)
			send(5, {$urandom, $urandom}, {$urandom, $urandom}, r0);
		for (int i = 0; i < 3; i++)
			send(int'($urandom % 5), {$urandom, $urandom}, {$urandom, $urandom}, r0);
		idle();
		drain();
		compare("issue_stall seen", 64'd1, 64'(saw_stall));
		end_test();

		// Codes 6 and 7 are dropped in the cycle they are presented.
		begin_test("illegal");
		beats0 = beats;
		send(6, {$urandom, $urandom}, {$urandom, $urandom}, r0);
		send(7, {$urandom, $urandom}, {$urandom, $urandom}, r1);
		idle();
		repeat (10) @(negedge clock);
		compare("beats after illegal", 64'(beats0), 64'(beats));
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none
// ===============================================
// Single-cycle adder unit with a result hold register.
// The result requests the CDB until it is granted.
// ===============================================

module alu_unit
	import ooo_pkg::*;
#(
	parameter int PRF_SIZE = 64,
	parameter int ROB_SIZE = 32,
	localparam int TAG_W = $clog2(PRF_SIZE),
	localparam int ROB_W = $clog2(ROB_SIZE) + 1
)
(
	input  wire logic              clock,
	input  wire logic              arst_n,
	input  wire logic              start,
	input  wire alu_op_e           alu_op,
	input  wire logic [DATA_W-1:0] op_a,
	input  wire logic [DATA_W-1:0] op_b,
	input  wire logic [TAG_W-1:0]  op_tag,
	input  wire logic [ROB_W-1:0]  op_rob,
	input  wire logic              grant,
	output logic                   req,
	output logic                   busy,
	output logic [DATA_W-1:0]      result,
	output logic [TAG_W-1:0]       res_tag,
	output logic [ROB_W-1:0]       res_rob
);

	logic [DATA_W-1:0] alu_res;

	// Combinational ALU.
	always_comb
	begin
		case (alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_XOR: alu_res = op_a ^ op_b;
			default: alu_res = '0;
		endcase
	end

	// A new result wins over a grant on the same edge.
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			req <= 1'b0;
		else if (start)
			req <= 1'b1;
		else if (grant)
			req <= 1'b0;
	end

	// Hold register for the result and its tags.
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			result  <= alu_res;
			res_tag <= op_tag;
			res_rob <= op_rob;
		end
	end

	// Free again in the cycle the held result is granted.
	assign busy = req & ~grant;

	// Decode must never start a unit that still holds a result.
	start_while_busy_a: assert property (@(posedge clock) disable iff (!arst_n)
		!(start && busy))
		else $error("alu_unit: start while holding an ungranted result");

endmodule

`default_nettype wire

// File: hw/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
// ===============================================
// Fixed-priority CDB arbiter. The highest request bit wins,
// so mult1 beats mult2, which beats adder1, then adder2.
// ===============================================

module cdb_arbiter
	import ooo_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              arst_n,
	input  wire logic [NUM_FU-1:0] req,
	output logic [NUM_FU-1:0]      grant
);

	// ===============================================
	// Grant logic
	// ===============================================

	// Walk upward so that a higher request overrides a lower one.
	always_comb
	begin
		grant = '0;
		for (int i = 0; i < NUM_FU; i++)
		begin
			if (req[i])
			begin
				grant    = '0;
				grant[i] = 1'b1;
			end
		end
	end

	// ===============================================
	// Checks
	// ===============================================

	// Only a requesting unit may be granted.
	grant_subset_a: assert property (@(posedge clock) disable iff (!arst_n)
		(grant & ~req) == '0)
		else $error("cdb_arbiter: grant without request");

	// One bus, one driver.
	grant_onehot_a: assert property (@(posedge clock) disable iff (!arst_n)
		$onehot0(grant))
		else $error("cdb_arbiter: multi-hot grant");

endmodule

`default_nettype wire

// File: hw/cdb_one_entry.sv
`timescale 1ns/1ps
`default_nettype none
// ===============================================
// CDB mux. Routes the granted unit's result, tag and ROB
// index onto the bus from the one-hot select.
// ===============================================

module cdb_one_entry
	import ooo_pkg::*;
#(
	parameter int PRF_SIZE = 64,
	parameter int ROB_SIZE = 32,
	localparam int TAG_W = $clog2(PRF_SIZE),
	localparam int ROB_W = $clog2(ROB_SIZE) + 1
)
(
	// Select order is mult1, mult2, adder1, adder2 from the top bit.
	input  wire logic [NUM_FU-1:0] fu_select,
	input  wire logic [DATA_W-1:0] mult1_result_in,
	input  wire logic [TAG_W-1:0]  mult1_dest_reg_idx,
	input  wire logic [ROB_W-1:0]  mult1_rob_idx,
	input  wire logic [DATA_W-1:0] mult2_result_in,
	input  wire logic [TAG_W-1:0]  mult2_dest_reg_idx,
	input  wire logic [ROB_W-1:0]  mult2_rob_idx,
	input  wire logic [DATA_W-1:0] adder1_result_in,
	input  wire logic [TAG_W-1:0]  adder1_dest_reg_idx,
	input  wire logic [ROB_W-1:0]  adder1_rob_idx,
	input  wire logic [DATA_W-1:0] adder2_result_in,
	input  wire logic [TAG_W-1:0]  adder2_dest_reg_idx,
	input  wire logic [ROB_W-1:0]  adder2_rob_idx,
	output logic                   cdb_valid,
	output logic [TAG_W-1:0]       cdb_tag,
	output logic [DATA_W-1:0]      cdb_out,
	output logic [ROB_W-1:0]       cdb_rob_idx
);

	always_comb
	begin
		// Idle bus by default.
		cdb_valid   = 1'b0;
		cdb_tag     = '0;
		cdb_out     = '0;
		cdb_rob_idx = '0;
		case (fu_select)
			SEL_MUL1:
			begin
				cdb_valid   = 1'b1;
				cdb_tag     = mult1_dest_reg_idx;
				cdb_out     = mult1_result_in;
				cdb_rob_idx = mult1_rob_idx;
			end
			SEL_MUL2:
			begin
				cdb_valid   = 1'b1;
				cdb_tag     = mult2_dest_reg_idx;
				cdb_out     = mult2_result_in;
				cdb_rob_idx = mult2_rob_idx;
			end
			SEL_ADD1:
			begin
				cdb_valid   = 1'b1;
				cdb_tag     = adder1_dest_reg_idx;
				cdb_out     = adder1_result_in;
				cdb_rob_idx = adder1_rob_idx;
			end
			SEL_ADD2:
			begin
				cdb_valid   = 1'b1;
				cdb_tag     = adder2_dest_reg_idx;
				cdb_out     = adder2_result_in;
				cdb_rob_idx = adder2_rob_idx;
			end
			default:
			begin
				// No grant, or a malformed select. Bus stays idle.
				cdb_valid = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/exec_cluster_top.sv
`timescale 1ns/1ps
`default_nettype none
// ===============================================
// Execution cluster top. Issue decode, two adders, two
// multipliers, the CDB arbiter and the CDB mux.
// ===============================================

module exec_cluster_top
	import ooo_pkg::*;
#(
	parameter int PRF_SIZE = 64,
	parameter int ROB_SIZE = 32,
	localparam int TAG_W = $clog2(PRF_SIZE),
	localparam int ROB_W = $clog2(ROB_SIZE) + 1
)
(
	input  wire logic              clock,
	input  wire logic              arst_n,
	input  wire logic              issue_valid,
	input  wire op_e               issue_op,
	input  wire logic [DATA_W-1:0] issue_a,
	input  wire logic [DATA_W-1:0] issue_b,
	input  wire logic [TAG_W-1:0]  issue_tag,
	input  wire logic [ROB_W-1:0]  issue_rob,
	output logic                   issue_stall,
	output logic                   issue_illegal,
	output logic                   cdb_valid,
	output logic [TAG_W-1:0]       cdb_tag,
	output logic [DATA_W-1:0]      cdb_out,
	output logic [ROB_W-1:0]       cdb_rob_idx
);

	// Decode to units.
	logic              add1_start, add2_start, mul1_start, mul2_start;
	alu_op_e           alu_op;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [TAG_W-1:0]  op_tag;
	logic [ROB_W-1:0]  op_rob;

	// Units to decode and to the CDB.
	logic              add1_req, add2_req, mul1_req, mul2_req;
	logic              add1_busy, add2_busy, mul1_busy, mul2_busy;
	logic [DATA_W-1:0] add1_result, add2_result, mul1_result, mul2_result;
	logic [TAG_W-1:0]  add1_tag, add2_tag, mul1_tag, mul2_tag;
	logic [ROB_W-1:0]  add1_rob, add2_rob, mul1_rob, mul2_rob;

	// One-hot grant, bit order from the package.
	logic [NUM_FU-1:0] grant;

	issue_decode #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_decode (
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b),
		.issue_tag(issue_tag), .issue_rob(issue_rob),
		.add1_busy(add1_busy), .add2_busy(add2_busy),
		.mul1_busy(mul1_busy), .mul2_busy(mul2_busy),
		.issue_stall(issue_stall), .issue_illegal(issue_illegal),
		.add1_start(add1_start), .add2_start(add2_start),
		.mul1_start(mul1_start), .mul2_start(mul2_start),
		.alu_op(alu_op), .op_a(op_a), .op_b(op_b), .op_tag(op_tag), .op_rob(op_rob)
	);

	// ===============================================
	// Execute
	// ===============================================
	alu_unit #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_add1 (
		.clock(clock), .arst_n(arst_n), .start(add1_start), .alu_op(alu_op),
		.op_a(op_a), .op_b(op_b), .op_tag(op_tag), .op_rob(op_rob),
		.grant(grant[FU_ADD1]), .req(add1_req), .busy(add1_busy),
		.result(add1_result), .res_tag(add1_tag), .res_rob(add1_rob)
	);

	alu_unit #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_add2 (
		.clock(clock), .arst_n(arst_n), .start(add2_start), .alu_op(alu_op),
		.op_a(op_a), .op_b(op_b), .op_tag(op_tag), .op_rob(op_rob),
		.grant(grant[FU_ADD2]), .req(add2_req), .busy(add2_busy),
		.result(add2_result), .res_tag(add2_tag), .res_rob(add2_rob)
	);

	mult_unit #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_mul1 (
		.clock(clock), .arst_n(arst_n), .start(mul1_start),
		.op_a(op_a), .op_b(op_b), .op_tag(op_tag), .op_rob(op_rob),
		.grant(grant[FU_MUL1]), .req(mul1_req), .busy(mul1_busy),
		.result(mul1_result), .res_tag(mul1_tag), .res_rob(mul1_rob)
	);

	mult_unit #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_mul2 (
		.clock(clock), .arst_n(arst_n), .start(mul2_start),
		.op_a(op_a), .op_b(op_b), .op_tag(op_tag), .op_rob(op_rob),
		.grant(grant[FU_MUL2]), .req(mul2_req), .busy(mul2_busy),
		.result(mul2_result), .res_tag(mul2_tag), .res_rob(mul2_rob)
	);

	// ===============================================
	// Result broadcast
	// ===============================================
	cdb_arbiter u_arb (
		.clock(clock), .arst_n(arst_n),
		.req({mul1_req, mul2_req, add1_req, add2_req}), .grant(grant)
	);

	cdb_one_entry #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_cdb (
		.fu_select(grant),
		.mult1_result_in(mul1_result), .mult1_dest_reg_idx(mul1_tag),
		.mult1_rob_idx(mul1_rob),
		.mult2_result_in(mul2_result), .mult2_dest_reg_idx(mul2_tag),
		.mult2_rob_idx(mul2_rob),
		.adder1_result_in(add1_result), .adder1_dest_reg_idx(add1_tag),
		.adder1_rob_idx(add1_rob),
		.adder2_result_in(add2_result), .adder2_dest_reg_idx(add2_tag),
		.adder2_rob_idx(add2_rob),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
		.cdb_out(cdb_out), .cdb_rob_idx(cdb_rob_idx)
	);

endmodule

`default_nettype wire

// File: hw/issue_decode.sv
`timescale 1ns/1ps
`default_nettype none
// ===============================================
// Issue decode. Classifies the opcode, picks a free unit
// and answers the issue side with stall and illegal levels.
// ===============================================

module issue_decode
	import ooo_pkg::*;
#(
	parameter int PRF_SIZE = 64,
	parameter int ROB_SIZE = 32,
	localparam int TAG_W = $clog2(PRF_SIZE),
	localparam int ROB_W = $clog2(ROB_SIZE) + 1
)
(
	input  wire logic              issue_valid,
	input  wire op_e               issue_op,
	input  wire logic [DATA_W-1:0] issue_a,
	input  wire logic [DATA_W-1:0] issue_b,
	input  wire logic [TAG_W-1:0]  issue_tag,
	input  wire logic [ROB_W-1:0]  issue_rob,
	input  wire logic              add1_busy,
	input  wire logic              add2_busy,
	input  wire logic              mul1_busy,
	input  wire logic              mul2_busy,
	output logic                   issue_stall,
	output logic                   issue_illegal,
	output logic                   add1_start,
	output logic                   add2_start,
	output logic                   mul1_start,
	output logic                   mul2_start,
	output alu_op_e                alu_op,
	output logic [DATA_W-1:0]      op_a,
	output logic [DATA_W-1:0]      op_b,
	output logic [TAG_W-1:0]       op_tag,
	output logic [ROB_W-1:0]       op_rob
);

	unit_class_e op_class;
	logic        accept;

	// Opcode to class, and ALU opcodes to the adder operation.
	always_comb
	begin
		op_class = CLASS_NONE;
		alu_op   = ALU_ADD;
		case (issue_op)
			OP_ADD: begin op_class = CLASS_ALU; alu_op = ALU_ADD; end
			OP_SUB: begin op_class = CLASS_ALU; alu_op = ALU_SUB; end
			OP_AND: begin op_class = CLASS_ALU; alu_op = ALU_AND; end
			OP_OR:  begin op_class = CLASS_ALU; alu_op = ALU_OR;  end
			OP_XOR: begin op_class = CLASS_ALU; alu_op = ALU_XOR; end
			OP_MUL: op_class = CLASS_MUL;
			default: op_class = CLASS_NONE;
		endcase
	end

	// Illegal opcodes are flagged and dropped in the same cycle.
	assign issue_illegal = issue_valid && (op_class == CLASS_NONE);

	// Stall only when both units of the needed class are holding results.
	assign issue_stall = issue_valid &&
		(((op_class == CLASS_ALU) && add1_busy && add2_busy) ||
		 ((op_class == CLASS_MUL) && mul1_busy && mul2_busy));

	assign accept = issue_valid && !issue_stall;

	// Unit 1 first, unit 2 only when unit 1 is busy.
	assign add1_start = accept && (op_class == CLASS_ALU) && !add1_busy;
	assign add2_start = accept && (op_class == CLASS_ALU) && add1_busy && !add2_busy;
	assign mul1_start = accept && (op_class == CLASS_MUL) && !mul1_busy;
	assign mul2_start = accept && (op_class == CLASS_MUL) && mul1_busy && !mul2_busy;

	// Operands, tag and ROB index are shared by all four units.
	assign op_a   = issue_a;
	assign op_b   = issue_b;
	assign op_tag = issue_tag;
	assign op_rob = issue_rob;

	// At most one unit may be started per cycle.
	always_comb
	begin
		assert ($onehot0({add1_start, add2_start, mul1_start, mul2_start}))
			else $error("issue_decode: more than one start strobe");
	end

endmodule

`default_nettype wire

// File: hw/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none
// ===============================================
// Three-stage pipelined multiplier, low half of the product.
// The whole pipe freezes while its output waits for the CDB.
// ===============================================

module mult_unit
	import ooo_pkg::*;
#(
	parameter int PRF_SIZE = 64,
	parameter int ROB_SIZE = 32,
	localparam int TAG_W = $clog2(PRF_SIZE),
	localparam int ROB_W = $clog2(ROB_SIZE) + 1
)
(
	input  wire logic              clock,
	input  wire logic              arst_n,
	input  wire logic              start,
	input  wire logic [DATA_W-1:0] op_a,
	input  wire logic [DATA_W-1:0] op_b,
	input  wire logic [TAG_W-1:0]  op_tag,
	input  wire logic [ROB_W-1:0]  op_rob,
	input  wire logic              grant,
	output logic                   req,
	output logic                   busy,
	output logic [DATA_W-1:0]      result,
	output logic [TAG_W-1:0]       res_tag,
	output logic [ROB_W-1:0]       res_rob
);

	localparam int HALF_W = DATA_W / 2;

	// Stage valid bits.
	logic v1;
	logic v2;
	logic v3;
	logic freeze;

	// Stage 1 holds the three partial products that reach the low half.
	logic [DATA_W-1:0] s1_ll;
	logic [HALF_W-1:0] s1_lh;
	logic [HALF_W-1:0] s1_hl;
	logic [TAG_W-1:0]  s1_tag;
	logic [ROB_W-1:0]  s1_rob;

	// Stage 2 holds the low product and the summed cross terms.
	logic [DATA_W-1:0] s2_ll;
	logic [HALF_W-1:0] s2_cross;
	logic [TAG_W-1:0]  s2_tag;
	logic [ROB_W-1:0]  s2_rob;

	// Output stage is valid but not taken.
	assign freeze = v3 & ~grant;
	assign busy   = freeze;
	assign req    = v3;

	// ===============================================
	// Valid chain
	// ===============================================
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end
		else if (!freeze)
		begin
			v1 <= start;
			v2 <= v1;
			v3 <= v2;
		end
	end

	// ===============================================
	// Datapath
	// ===============================================
	always_ff @(posedge clock)
	begin
		if (!freeze)
		begin
			// Only the low halves of the cross products matter.
			s1_ll    <= op_a[HALF_W-1:0] * op_b[HALF_W-1:0];
			s1_lh    <= op_a[HALF_W-1:0] * op_b[DATA_W-1:HALF_W];
			s1_hl    <= op_a[DATA_W-1:HALF_W] * op_b[HALF_W-1:0];
			s1_tag   <= op_tag;
			s1_rob   <= op_rob;
			s2_ll    <= s1_ll;
			s2_cross <= s1_lh + s1_hl;
			s2_tag   <= s1_tag;
			s2_rob   <= s1_rob;
			// Cross terms land in the upper half.
			result   <= s2_ll + {s2_cross, {HALF_W{1'b0}}};
			res_tag  <= s2_tag;
			res_rob  <= s2_rob;
		end
	end

	// A waiting result must not change until it is granted.
	held_stable_a: assert property (@(posedge clock) disable iff (!arst_n)
		(req && !grant) |=>
		(req && $stable(result) && $stable(res_tag) && $stable(res_rob)))
		else $error("mult_unit: ungranted result changed");

endmodule

`default_nettype wire

// File: hw/ooo_pkg.sv
`default_nettype none
// ===============================================
// Shared types and constants of the execution cluster.
// Modules pull these in with a wildcard import.
// ===============================================

package ooo_pkg;

	// Operand and result width of every unit and of the CDB.
	localparam int DATA_W = 64;

	// ===============================================
	// CDB sources and their one-hot order
	// ===============================================

	// Number of units that can drive the CDB.
	localparam int NUM_FU = 4;

	// Bit positions in the request and grant vectors, highest priority first.
	localparam int FU_MUL1 = 3;
	localparam int FU_MUL2 = 2;
	localparam int FU_ADD1 = 1;
	localparam int FU_ADD2 = 0;

	// One-hot select codes as seen by the CDB mux.
	localparam logic [NUM_FU-1:0] SEL_MUL1 = NUM_FU'(1) << FU_MUL1;
	localparam logic [NUM_FU-1:0] SEL_MUL2 = NUM_FU'(1) << FU_MUL2;
	localparam logic [NUM_FU-1:0] SEL_ADD1 = NUM_FU'(1) << FU_ADD1;
	localparam logic [NUM_FU-1:0] SEL_ADD2 = NUM_FU'(1) << FU_ADD2;

	// ===============================================
	// Opcodes and decode classes
	// ===============================================

	// Issue opcode. Codes 6 and 7 are illegal.
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_MUL = 3'd5
	} op_e;

	// Operation handed to an adder.
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4
	} alu_op_e;

	// Which unit class an opcode needs.
	typedef enum logic [1:0] {
		CLASS_ALU  = 2'd0,
		CLASS_MUL  = 2'd1,
		CLASS_NONE = 2'd2
	} unit_class_e;

endpackage

`default_nettype wire

// File: tb.f
hw/ooo_pkg.sv
hw/issue_decode.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/cdb_arbiter.sv
hw/cdb_one_entry.sv
hw/exec_cluster_top.sv
bench/tb_exec_cluster.sv
